/* eccReg.f */
+incdir+source
source/eccRegPkg.sv
source/eccEnc.sv
source/eccDec.sv
source/eccReg.sv
source/eccRegTop.sv
tb/eccClkGen.sv
tb/eccRegTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the eccReg testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

verilator --binary --timing --assert -sv \
  --top-module eccRegTb \
  -f eccReg.f \
  -Mdir obj_dir \
  -o eccRegSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/eccRegSim
simStatus=$?
if [ $simStatus -ne 0 ]; then
  echo "Simulation failed with status $simStatus"
  exit $simStatus
fi

exit 0

/* source/eccDec.sv */
// SEC-DED syndrome decoder module eccDec with correction and status output

`timescale 1ns/1ps
`default_nettype none

`include "ecc_defs.svh"

module eccDec #(
  parameter int unsigned DataWidth = `ECC_DATA_WIDTH,
  // Derived widths
  localparam int unsigned HamBits   = `ECC_HAMMING_BITS(DataWidth),
  localparam int unsigned CodeWidth = `ECC_CODE_WIDTH(DataWidth)
) (
  input  logic [CodeWidth-1:0] i_code,
  output logic [DataWidth-1:0] o_data,
  output eccRegPkg::eccStatusE o_status,
  output logic [CodeWidth-1:0] o_code
);

  // Highest Hamming position
  localparam int unsigned HamLen = DataWidth + HamBits;

  logic [DataWidth-1:0] dataIn;
  logic [HamBits-1:0]   checkIn;
  logic [HamBits-1:0]   syndrome;
  logic                 parityOdd;
  logic                 synInRange;
  logic [CodeWidth-1:0] flipMask;

  // Split the systematic word
  assign dataIn  = i_code[DataWidth-1:0];
  assign checkIn = i_code[DataWidth+HamBits-1:DataWidth];

  // Parity of the whole word is odd after an odd number of flips
  assign parityOdd = ^i_code;

  // Syndrome is the XOR of the positions of all set bits
  // A clean codeword gives zero
  always_comb begin
    int   dataIdx;
    int   chkIdx;
    logic posBit;
    syndrome = '0;
    dataIdx  = 0;
    chkIdx   = 0;
    for (int pos = 1; pos <= HamLen; pos++) begin
      if ((pos & (pos - 1)) == 0) begin
        posBit = checkIn[chkIdx];
        chkIdx++;
      end else begin
        posBit = dataIn[dataIdx];
        dataIdx++;
      end
      if (posBit) begin
        syndrome = syndrome ^ HamBits'(pos);
      end
    end
  end

  // Syndromes past the last position come from three or more flips
  assign synInRange = (int'(syndrome) <= int'(HamLen));

  // Classify the error
  always_comb begin
    if (!parityOdd) begin
      // Even parity with a nonzero syndrome is a double error
      o_status = (syndrome == '0) ? eccRegPkg::ECC_OK : eccRegPkg::ECC_UNCORRECTABLE;
    end else if (synInRange) begin
      o_status = eccRegPkg::ECC_CORRECTED;
    end else begin
      o_status = eccRegPkg::ECC_UNCORRECTABLE;
    end
  end

  // Map the syndrome position back onto the systematic layout
  always_comb begin
    int dataIdx;
    int chkIdx;
    flipMask = '0;
    dataIdx  = 0;
    chkIdx   = 0;
    if (o_status == eccRegPkg::ECC_CORRECTED) begin
      if (syndrome == '0) begin
        // Only the overall parity bit is wrong
        flipMask[CodeWidth-1] = 1'b1;
      end else begin
        for (int pos = 1; pos <= HamLen; pos++) begin
          if ((pos & (pos - 1)) == 0) begin
            if (int'(syndrome) == pos) begin
              flipMask[DataWidth+chkIdx] = 1'b1;
            end
            chkIdx++;
          end else begin
            if (int'(syndrome) == pos) begin
              flipMask[dataIdx] = 1'b1;
            end
            dataIdx++;
          end
        end
      end
    end
  end

  // Mask is empty unless a single error was found
  assign o_code = i_code ^ flipMask;
  assign o_data = o_code[DataWidth-1:0];

  // A correction flips exactly one stored bit, any other status flips none
  always_comb begin
    assert ((o_status == eccRegPkg::ECC_CORRECTED) ? $onehot(flipMask) : (flipMask == '0))
      else $error("eccDec: flip mask does not match status %0d", o_status);
  end

endmodule

`default_nettype wire

/* source/eccEnc.sv */
// Combinational extended Hamming encoder module eccEnc with systematic output

`timescale 1ns/1ps
`default_nettype none

`include "ecc_defs.svh"

module eccEnc #(
  parameter int unsigned DataWidth = `ECC_DATA_WIDTH,
  // Derived widths
  localparam int unsigned HamBits   = `ECC_HAMMING_BITS(DataWidth),
  localparam int unsigned CodeWidth = `ECC_CODE_WIDTH(DataWidth)
) (
  input  logic [DataWidth-1:0] i_data,
  output logic [CodeWidth-1:0] o_code
);

  // Highest Hamming position with positions counting from 1
  localparam int unsigned HamLen = DataWidth + HamBits;

  logic [HamBits-1:0] checkBits;
  logic               overallBit;

  // Walk the Hamming positions in order
  // Data bits fill the non power-of-two slots from bit 0 upward
  always_comb begin
    int dataIdx;
    checkBits = '0;
    dataIdx   = 0;
    for (int pos = 1; pos <= HamLen; pos++) begin
      // Power-of-two slots belong to the check bits
      if ((pos & (pos - 1)) != 0) begin
        // Check bit j covers every position with bit j set
        for (int j = 0; j < HamBits; j++) begin
          if (pos[j]) begin
            checkBits[j] = checkBits[j] ^ i_data[dataIdx];
          end
        end
        dataIdx++;
      end
    end
  end

  // Overall parity over data and checks
  // Makes the full codeword even, which gives distance 4
  assign overallBit = ^{checkBits, i_data};

  // Systematic layout keeps the data readable in the low bits
  assign o_code = {overallBit, checkBits, i_data};

endmodule

`default_nettype wire

/* source/eccReg.sv */
// Codeword storage module eccReg with write, fault injection, scrub and error count

`timescale 1ns/1ps
`default_nettype none

`include "ecc_defs.svh"

module eccReg #(
  parameter int unsigned DataWidth = `ECC_DATA_WIDTH,
  localparam int unsigned CodeWidth = `ECC_CODE_WIDTH(DataWidth)
) (
  input  logic                 i_clk,
  input  logic                 i_arstN,
  input  logic                 i_wrStrobe,
  input  logic [CodeWidth-1:0] i_wrCode,
  input  logic                 i_faultStrobe,
  input  logic [CodeWidth-1:0] i_faultMask,
  input  logic                 i_scrubEn,
  input  eccRegPkg::eccStatusE i_status,
  input  logic [CodeWidth-1:0] i_fixedCode,
  output logic [CodeWidth-1:0] o_code,
  output logic [7:0]           o_errCount
);

  eccRegPkg::eccUpdE    updSel;
  logic [CodeWidth-1:0] loadCode;
  logic [CodeWidth-1:0] nextCode;
  logic                 errSeen;

  // Write wins over scrub
  // Uncorrectable words are left alone until rewritten
  always_comb begin
    if (i_wrStrobe) begin
      updSel = eccRegPkg::UPD_WRITE;
    end else if (i_scrubEn && (i_status == eccRegPkg::ECC_CORRECTED)) begin
      updSel = eccRegPkg::UPD_SCRUB;
    end else begin
      updSel = eccRegPkg::UPD_HOLD;
    end
  end

  always_comb begin
    case (updSel)
      eccRegPkg::UPD_WRITE: loadCode = i_wrCode;
      eccRegPkg::UPD_SCRUB: loadCode = i_fixedCode;
      default:              loadCode = o_code;
    endcase
  end

  // Fault mask lands on top of whatever is loaded or held
  assign nextCode = i_faultStrobe ? (loadCode ^ i_faultMask) : loadCode;

  // Reset value is the codeword of zero, which is all zeros
  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      o_code <= '0;
    end else begin
      o_code <= nextCode;
    end
  end

  // Every cycle ends in a load or a hold, so count each bad status cycle
  assign errSeen = (i_status != eccRegPkg::ECC_OK);

  // Saturating event counter
  always_ff @(posedge i_clk or negedge i_arstN) begin
    if (!i_arstN) begin
      o_errCount <= 8'd0;
    end else if (errSeen && (o_errCount != 8'hFF)) begin
      o_errCount <= o_errCount + 8'd1;
    end
  end

  // Uncorrectable word is held untouched until a write or a fault
  assert property (@(posedge i_clk) disable iff (!i_arstN)
    ((i_status == eccRegPkg::ECC_UNCORRECTABLE) && !i_wrStrobe && !i_faultStrobe)
      |=> $stable(o_code))
    else $error("eccReg: uncorrectable word changed without a write");

  // Clean scrub leaves a clean codeword one edge later
  assert property (@(posedge i_clk) disable iff (!i_arstN)
    ((updSel == eccRegPkg::UPD_SCRUB) && !i_faultStrobe) |=> (i_status == eccRegPkg::ECC_OK))
    else $error("eccReg: status not OK after scrub write-back");

endmodule

`default_nettype wire

/* source/eccRegPkg.sv */
// Package eccRegPkg with decode status and register update-source enums

`default_nettype none

package eccRegPkg;

  // Decoder verdict on the stored codeword
  typedef enum logic [1:0] {
    ECC_OK            = 2'd0,
    ECC_CORRECTED     = 2'd1,
    ECC_UNCORRECTABLE = 2'd2
  } eccStatusE;

  // What the storage register loads on the next edge
  typedef enum logic [1:0] {
    UPD_HOLD  = 2'd0,
    UPD_WRITE = 2'd1,
    UPD_SCRUB = 2'd2
  } eccUpdE;

endpackage

`default_nettype wire

/* source/eccRegTop.sv */
// Top module eccRegTop joining the encoder, storage register and decoder

`timescale 1ns/1ps
`default_nettype none

`include "ecc_defs.svh"

module eccRegTop #(
  parameter int unsigned DataWidth = `ECC_DATA_WIDTH,
  localparam int unsigned CodeWidth = `ECC_CODE_WIDTH(DataWidth)
) (
  input  logic                 i_clk,
  input  logic                 i_arstN,
  input  logic                 i_wrStrobe,
  input  logic [DataWidth-1:0] i_wrData,
  input  logic                 i_faultStrobe,
  input  logic [CodeWidth-1:0] i_faultMask,
  input  logic                 i_scrubEn,
  output logic [DataWidth-1:0] o_rdData,
  output eccRegPkg::eccStatusE o_status,
  output logic [7:0]           o_errCount
);

  // Codeword paths between the three blocks
  logic [CodeWidth-1:0] wrCode;
  logic [CodeWidth-1:0] storedCode;
  logic [CodeWidth-1:0] fixedCode;

  // Write side encoder
  eccEnc #(
    .DataWidth (DataWidth)
  ) uEnc (
    .i_data (i_wrData),
    .o_code (wrCode)
  );

  // Storage with fault injection and scrub
  eccReg #(
    .DataWidth (DataWidth)
  ) uReg (
    .i_clk         (i_clk),
    .i_arstN       (i_arstN),
    .i_wrStrobe    (i_wrStrobe),
    .i_wrCode      (wrCode),
    .i_faultStrobe (i_faultStrobe),
    .i_faultMask   (i_faultMask),
    .i_scrubEn     (i_scrubEn),
    .i_status      (o_status),
    .i_fixedCode   (fixedCode),
    .o_code        (storedCode),
    .o_errCount    (o_errCount)
  );

  // Read side decoder, runs continuously on the stored word
  eccDec #(
    .DataWidth (DataWidth)
  ) uDec (
    .i_code   (storedCode),
    .o_data   (o_rdData),
    .o_status (o_status),
    .o_code   (fixedCode)
  );

endmodule

`default_nettype wire

/* source/ecc_defs.svh */
// Macros for ECC data width, Hamming check-bit count and codeword width

`ifndef ECC_DEFS_SVH
`define ECC_DEFS_SVH

// Default data width of the protected register
`define ECC_DATA_WIDTH 32

// Smallest r with 2**r >= w + r + 1
// Each threshold is the largest width a given r still covers
// Widths up to 120 are listed, the register itself is used up to 64
`define ECC_HAMMING_BITS(w) \
  (((w) <=   1) ? 2 : \
   ((w) <=   4) ? 3 : \
   ((w) <=  11) ? 4 : \
   ((w) <=  26) ? 5 : \
   ((w) <=  57) ? 6 : \
   ((w) <= 120) ? 7 : 8)

// Systematic layout
// Data in the low bits, Hamming checks above, overall parity on top
`define ECC_CODE_WIDTH(w) ((w) + `ECC_HAMMING_BITS(w) + 1)

`endif

/* tb/eccClkGen.sv */
// Free-running testbench clock module eccClkGen with a 4 ns period

`timescale 1ns/1ps
`default_nettype none

module eccClkGen #(
  parameter int unsigned HalfPeriod = 2
) (
  output logic o_clk
);

  // Starts low so the first rising edge lands at HalfPeriod
  initial begin
    o_clk = 1'b0;
  end

  always #(HalfPeriod) o_clk = ~o_clk;

endmodule

`default_nettype wire

/* tb/eccRegTb.sv */
// Table-driven testbench module eccRegTb for the ECC register with timeout and result report

`timescale 1ns/1ps
`default_nettype none

`include "ecc_defs.svh"

module eccRegTb;

  localparam int unsigned DataWidth = `ECC_DATA_WIDTH;
  localparam int unsigned CodeWidth = `ECC_CODE_WIDTH(DataWidth);
  localparam int          MaxRows   = 40;

  typedef enum int {OP_IDLE, OP_WRITE, OP_FAULT} opE;

  logic                 clk;
  logic                 arstN;
  logic                 wrStrobe;
  logic [DataWidth-1:0] wrData;
  logic                 faultStrobe;
  logic [CodeWidth-1:0] faultMask;
  logic                 scrubEn;
  logic [DataWidth-1:0] rdData;
  eccRegPkg::eccStatusE rdStatus;
  logic [7:0]           errCount;

  // Stimulus table with one entry per clock cycle
  string                rowName[MaxRows];
  opE                   rowOp[MaxRows];
  logic [DataWidth-1:0] rowData[MaxRows];
  logic [CodeWidth-1:0] rowMask[MaxRows];
  logic                 rowScrub[MaxRows];
  logic [DataWidth-1:0] rowExpData[MaxRows];
  eccRegPkg::eccStatusE rowExpStatus[MaxRows];
  int                   numRows = 0;

  int          cycleCount   = 0;
  int          timeoutLimit = 50;

  eccClkGen uClk (
    .o_clk (clk)
  );

  eccRegTop #(
    .DataWidth (DataWidth)
  ) uut (
    .i_clk         (clk),
    .i_arstN       (arstN),
    .i_wrStrobe    (wrStrobe),
    .i_wrData      (wrData),
    .i_faultStrobe (faultStrobe),
    .i_faultMask   (faultMask),
    .i_scrubEn     (scrubEn),
    .o_rdData      (rdData),
    .o_status      (rdStatus),
    .o_errCount    (errCount)
  );

  task automatic checkVal(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "Check %s failed", name);
    end
  endtask

  task automatic addRow(input string name, input opE op, input logic [DataWidth-1:0] data,
                        input logic [CodeWidth-1:0] mask, input logic scrub,
                        input logic [DataWidth-1:0] expData,
                        input eccRegPkg::eccStatusE expStatus);
    rowName[numRows]      = name;
    rowOp[numRows]        = op;
    rowData[numRows]      = data;
    rowMask[numRows]      = mask;
    rowScrub[numRows]     = scrub;
    rowExpData[numRows]   = expData;
    rowExpStatus[numRows] = expStatus;
    numRows++;
  endtask

  // Single set bit at a codeword position
  function automatic logic [CodeWidth-1:0] bitMask(input int pos);
    return CodeWidth'(1) << pos;
  endfunction

  task automatic buildTable();
    logic [DataWidth-1:0] wA;
    logic [DataWidth-1:0] wB;
    logic [DataWidth-1:0] wC;
    logic [CodeWidth-1:0] dblB;
    logic [CodeWidth-1:0] dblC;
    wA   = DataWidth'($urandom());
    wB   = DataWidth'($urandom());
    wC   = DataWidth'($urandom());
    // Two data bits and a data bit paired with a check bit
    dblB = bitMask(3) | bitMask(20);
    dblC = bitMask(0) | bitMask(DataWidth + 1);
    // One flip per region with scrub off
    addRow("write A", OP_WRITE, wA, '0, 1'b0, wA, eccRegPkg::ECC_OK);
    addRow("idle A", OP_IDLE, '0, '0, 1'b0, wA, eccRegPkg::ECC_OK);
    addRow("flip data bit", OP_FAULT, '0, bitMask(5), 1'b0, wA, eccRegPkg::ECC_CORRECTED);
    addRow("hold data flip", OP_IDLE, '0, '0, 1'b0, wA, eccRegPkg::ECC_CORRECTED);
    addRow("rewrite A", OP_WRITE, wA, '0, 1'b0, wA, eccRegPkg::ECC_OK);
    addRow("flip check bit", OP_FAULT, '0, bitMask(DataWidth + 2), 1'b0, wA,
           eccRegPkg::ECC_CORRECTED);
    addRow("hold check flip", OP_IDLE, '0, '0, 1'b0, wA, eccRegPkg::ECC_CORRECTED);
    addRow("write B", OP_WRITE, wB, '0, 1'b0, wB, eccRegPkg::ECC_OK);
    addRow("flip overall bit", OP_FAULT, '0, bitMask(CodeWidth - 1), 1'b0, wB,
           eccRegPkg::ECC_CORRECTED);
    addRow("hold overall flip", OP_IDLE, '0, '0, 1'b0, wB, eccRegPkg::ECC_CORRECTED);
    // Scrub fixes a pending single error on its own
    addRow("scrub overall", OP_IDLE, '0, '0, 1'b1, wB, eccRegPkg::ECC_OK);
    addRow("scrub flip data", OP_FAULT, '0, bitMask(17), 1'b1, wB, eccRegPkg::ECC_CORRECTED);
    addRow("scrub data done", OP_IDLE, '0, '0, 1'b1, wB, eccRegPkg::ECC_OK);
    addRow("scrub flip check", OP_FAULT, '0, bitMask(DataWidth), 1'b1, wB,
           eccRegPkg::ECC_CORRECTED);
    addRow("scrub check done", OP_IDLE, '0, '0, 1'b1, wB, eccRegPkg::ECC_OK);
    addRow("scrub idle", OP_IDLE, '0, '0, 1'b1, wB, eccRegPkg::ECC_OK);
    // Double errors pass raw data through and are never scrubbed
    addRow("double flip data", OP_FAULT, '0, dblB, 1'b0, wB ^ dblB[DataWidth-1:0],
           eccRegPkg::ECC_UNCORRECTABLE);
    addRow("double stays 1", OP_IDLE, '0, '0, 1'b1, wB ^ dblB[DataWidth-1:0],
           eccRegPkg::ECC_UNCORRECTABLE);
    addRow("double stays 2", OP_IDLE, '0, '0, 1'b1, wB ^ dblB[DataWidth-1:0],
           eccRegPkg::ECC_UNCORRECTABLE);
    addRow("write C", OP_WRITE, wC, '0, 1'b1, wC, eccRegPkg::ECC_OK);
    addRow("double flip mixed", OP_FAULT, '0, dblC, 1'b1, wC ^ dblC[DataWidth-1:0],
           eccRegPkg::ECC_UNCORRECTABLE);
    addRow("double mixed stays", OP_IDLE, '0, '0, 1'b1, wC ^ dblC[DataWidth-1:0],
           eccRegPkg::ECC_UNCORRECTABLE);
    addRow("rewrite C", OP_WRITE, wC, '0, 1'b0, wC, eccRegPkg::ECC_OK);
    addRow("final idle", OP_IDLE, '0, '0, 1'b0, wC, eccRegPkg::ECC_OK);
  endtask

  // Row j's status is counted at the edge of row j+1 so the last row adds nothing
  function automatic int predictErrCount();
    int cnt;
    cnt = 0;
    for (int j = 0; j < numRows - 1; j++) begin
      if ((rowExpStatus[j] != eccRegPkg::ECC_OK) && (cnt < 255)) begin
        cnt++;
      end
    end
    return cnt;
  endfunction

  task automatic driveIdle();
    wrStrobe    = 1'b0;
    wrData      = '0;
    faultStrobe = 1'b0;
    faultMask   = '0;
    scrubEn     = 1'b0;
  endtask

  task automatic applyRow(input int i);
    wrStrobe    = (rowOp[i] == OP_WRITE);
    wrData      = rowData[i];
    faultStrobe = (rowOp[i] == OP_FAULT);
    faultMask   = rowMask[i];
    scrubEn     = rowScrub[i];
  endtask

  // Run limit scales with the table length
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= timeoutLimit) begin
      $display("*** FAILED ***");
      $fatal(1, "Timeout after %0d cycles, the table did not finish", cycleCount);
    end
  end

  initial begin
    arstN = 1'b0;
    driveIdle();
    // Seed the random write data once
    void'($urandom(50));
    buildTable();
    timeoutLimit = numRows * 4 + 50;
    repeat (5) @(posedge clk);
    #1;
    arstN = 1'b1;
    // Clean state right after reset
    #2;
    checkVal("reset data", 64'(0), 64'(rdData));
    checkVal("reset status", 64'(eccRegPkg::ECC_OK), 64'(rdStatus));
    checkVal("reset errCount", 64'(0), 64'(errCount));
    // Row i is driven after an edge and row i-1 is checked just before the next one
    for (int i = 0; i <= numRows; i++) begin
      @(posedge clk);
      #1;
      if (i < numRows) begin
        applyRow(i);
      end else begin
        driveIdle();
      end
      #2;
      if (i > 0) begin
        checkVal({rowName[i-1], " data"}, 64'(rowExpData[i-1]), 64'(rdData));
        checkVal({rowName[i-1], " status"}, 64'(rowExpStatus[i-1]), 64'(rdStatus));
      end
    end
    checkVal("final errCount", 64'(predictErrCount()), 64'(errCount));
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
